// ==== sources.f ====
mmix_dec_pkg.sv
dec_fetch_stage.sv
dec_operand_spec.sv
dec_dest_rename.sv
dec_out_buffer.sv
inst_decoder_top.sv
tb_inst_decoder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the decoder testbench with Verilator, run it and check the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_inst_decoder \
	-f sources.f -o tb_sim &&
{ ./obj_dir/tb_sim > sim.log 2>&1; cat sim.log; } &&
grep -q '^STATUS: PASS$' sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tb_inst_decoder.sv ====
/*
 * Testbench for the MMIX decode front end.
 * Streams random instructions through the input side, predicts every
 * decoded item and checks the output stream against the prediction in order.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_inst_decoder
	import mmix_dec_pkg::*;
();

	localparam int MAX_CYCLES = 5000;
	localparam int SB_DEPTH = 1024;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	fetch_t in_item;
	logic out_valid;
	logic out_ready = 1'b0;
	decoded_t out_item;

	logic [63:0] stim_rng;
	logic [63:0] ready_rng;
	logic steady_mode;
	int cycle = 0;

	// scoreboard with one slot per accepted item
	decoded_t exp_mem [0:SB_DEPTH-1];
	int exp_cycle [0:SB_DEPTH-1];
	logic exp_steady [0:SB_DEPTH-1];
	int wr_idx = 0;
	int rd_idx = 0;
	decoded_t exp_head;
	int head_cycle;
	logic head_steady;

	assign exp_head = exp_mem[rd_idx % SB_DEPTH];
	assign head_cycle = exp_cycle[rd_idx % SB_DEPTH];
	assign head_steady = exp_steady[rd_idx % SB_DEPTH];

	inst_decoder_top UUT (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_item (in_item),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_item (out_item)
	);

	always #10 clk = ~clk;

	task automatic value_mismatch(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		$display("STATUS: FAIL");
		$fatal(1, "decoder check failed");
	endtask

	task automatic run_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "run aborted");
	endtask

	function automatic logic [63:0] xorshift64(input logic [63:0] s);
		logic [63:0] t;
		t = s ^ (s << 13);
		t = t ^ (t >> 7);
		t = t ^ (t << 17);
		return t;
	endfunction

	function automatic logic [63:0] rand64();
		stim_rng = xorshift64(stim_rng);
		return stim_rng;
	endfunction

	// global at or above G and otherwise a slot of the 256-entry local ring
	function automatic spec_t ring_map(input logic [7:0] idx, input ring_t ring);
		spec_t s;
		logic [RING_W-1:0] sum;
		s = '0;
		sum = ring.o + {{(RING_W-8){1'b0}}, idx};
		if (idx >= ring.g) begin
			s.src = SRC_GLOBAL;
			s.regno = idx;
		end else begin
			s.src = SRC_LOCAL;
			s.regno = sum[7:0];
		end
		return s;
	endfunction

	// reference decode of one fetched item
	function automatic decoded_t expect_decode(input fetch_t it);
		decoded_t d;
		logic [7:0] op;
		logic [7:0] xx;
		logic [7:0] yy;
		logic [7:0] zz;
		logic [15:0] yz;
		logic wr_x, rd_x, y_reg, y_imm, has_z, rel, live;
		longint off;
		spec_t xmap;
		op = it.inst[31:24];
		xx = it.inst[23:16];
		yy = it.inst[15:8];
		zz = it.inst[7:0];
		yz = it.inst[15:0];
		d = '0;
		d.loc = it.loc;
		d.iop = op_trap;
		{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b000000;
		if (op inside {[8'h20:8'h3F]}) begin
			// NEG and NEGU take Y as a plain number
			if (op inside {[8'h34:8'h37]})
				{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b100110;
			else
				{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b101010;
			case (op & 8'hFE)
			8'h20: d.iop = op_add;
			8'h22, 8'h28, 8'h2A, 8'h2C, 8'h2E: d.iop = op_addu;
			8'h24, 8'h34: d.iop = op_sub;
			8'h26, 8'h36: d.iop = op_subu;
			8'h30: d.iop = op_cmp;
			8'h32: d.iop = op_cmpu;
			8'h38, 8'h3A: d.iop = op_shl;
			default: d.iop = op_shr;
			endcase
		end else if (op inside {[8'h40:8'h5F]}) begin
			// branch tests X and probable forms sit in the upper half
			d.iop = (op >= 8'h50) ? op_pbr : op_br;
			{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b010001;
		end else if (op inside {[8'h60:8'h6F]}) begin
			d.iop = op_cset;
			{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b111010;
		end else if (op inside {[8'h70:8'h7F]}) begin
			d.iop = op_zset;
			{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b101010;
		end else if (op inside {[8'h80:8'h8F]}) begin
			d.iop = op_ld;
			{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b101010;
		end else if (op inside {[8'hA0:8'hAF]}) begin
			d.iop = op_st;
			{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b011010;
		end else if (op inside {[8'hC0:8'hCF]}) begin
			d.iop = (op < 8'hC8) ? op_or : op_and;
			{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b101010;
		end else if (op inside {[8'hE0:8'hEF]}) begin
			case (op[3:2])
			2'd0: d.iop = op_set;
			2'd1: d.iop = op_addu;
			2'd2: d.iop = op_or;
			default: d.iop = op_and;
			endcase
			// everything but SETx folds into the old rX
			if (op < 8'hE4)
				{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b100000;
			else
				{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b110000;
		end else if (op == 8'hF0 || op == 8'hF1) begin
			d.iop = op_jmp;
			{wr_x, rd_x, y_reg, y_imm, has_z, rel} = 6'b000001;
		end

		if (rel) begin
			// odd opcode means a backward offset
			if (d.iop == op_jmp)
				off = longint'({40'b0, it.inst[23:0]}) - (op[0] ? 64'sd16777216 : 64'sd0);
			else
				off = longint'({48'b0, yz}) - (op[0] ? 64'sd65536 : 64'sd0);
			d.y.val = it.loc + 64'd4;
			d.z.val = it.loc + 64'(off * 4);
		end else begin
			if (y_imm)
				d.y.val = {56'b0, yy};
			else if (y_reg)
				d.y = ring_map(yy, it.ring);
			if (op[7:4] == 4'hE) begin
				d.z.val = {48'b0, yz} << (16 * (3 - op[1:0]));
				if (rd_x)
					d.y = ring_map(xx, it.ring);
			end else if (has_z) begin
				if (op[0])
					d.z.val = {56'b0, zz};
				else
					d.z = ring_map(zz, it.ring);
			end
		end

		// X between L and G is left unresolved
		live = (xx >= it.ring.g) || (xx < it.ring.l);
		xmap = ring_map(xx, it.ring);
		if (wr_x && live) begin
			d.x.ren = 1'b1;
			d.x.src = xmap.src;
			d.x.regno = xmap.regno;
		end
		d.marginal = wr_x && !live;
		if (rd_x && live)
			d.b = xmap;
		return d;
	endfunction

	function automatic logic [7:0] pick_op(input int kind, input logic [63:0] r);
		logic [7:0] op;
		case (kind)
		0: op = r[8] ? {4'hC, r[3:1], 1'b0} : {3'b001, r[4:1], 1'b0};
		1: case (r[1:0])
			2'd0: op = 8'h21;
			2'd1: op = 8'h35;
			2'd2: op = 8'h39;
			default: op = 8'h81;
			endcase
		2: op = {4'hE, r[3:0]};
		3: op = (r[4:3] == 2'b11) ? {7'h78, r[0]} : {3'b010, r[4:0]};
		4: case (r[2:0])
			3'd0: op = {3'b000, r[12:8]};
			3'd1: op = {4'h9, r[11:8]};
			3'd2: op = {4'hB, r[11:8]};
			3'd3: op = {4'hD, r[11:8]};
			3'd4: op = 8'hF2 + {4'h0, r[11:8] % 4'd14};
			default: op = {4'h1, r[11:8]};
			endcase
		// ops that write X
		5: case (r[2:0])
			3'd0: op = {3'b001, r[12:8]};
			3'd1: op = {4'h6, r[11:8]};
			3'd2: op = {4'h7, r[11:8]};
			3'd3: op = {4'h8, r[11:8]};
			3'd4: op = {4'hC, r[11:8]};
			default: op = {4'hE, r[11:8]};
			endcase
		default: op = r[7:0];
		endcase
		return op;
	endfunction

	// random ring state with L <= G and the item held until the decoder takes it
	task automatic send_op(input logic [7:0] op, input logic want_marginal);
		fetch_t it;
		logic [63:0] r;
		logic [63:0] ro;
		logic [63:0] rl;
		logic ok;
		r = rand64();
		ro = rand64();
		rl = rand64();
		it.ring.g = r[7:0];
		it.ring.l = 8'({1'b0, r[15:8]} % ({1'b0, r[7:0]} + 9'd1));
		it.ring.o = ro[60:0];
		it.loc = {rl[63:2], 2'b00};
		it.inst = {op, r[39:16]};
		if (want_marginal && it.ring.g > it.ring.l)
			it.inst[23:16] = it.ring.l + r[47:40] % (it.ring.g - it.ring.l);
		in_item <= it;
		in_valid <= 1'b1;
		ok = 1'b0;
		while (!ok) begin
			@(negedge clk);
			ok = in_ready;
			@(posedge clk);
		end
		in_valid <= 1'b0;
	endtask

	task automatic run_phase(input int kind, input int count);
		logic [63:0] r;
		for (int i = 0; i < count; i++) begin
			r = rand64();
			// occasional idle cycle but none in the steady phase
			if (!steady_mode && r[30:28] == 3'd0)
				@(posedge clk);
			send_op(pick_op(kind, r), kind == 5 || (kind == 6 && r[40]));
		end
	endtask

	task automatic drain();
		logic done;
		in_valid <= 1'b0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			done = (rd_idx == wr_idx) && !out_valid;
		end
		@(posedge clk);
	endtask

	always @(posedge clk) begin
		if (rst) begin
			wr_idx <= 0;
			rd_idx <= 0;
		end else begin
			if (in_valid && in_ready) begin
				exp_mem[wr_idx % SB_DEPTH] <= expect_decode(in_item);
				exp_cycle[wr_idx % SB_DEPTH] <= cycle;
				exp_steady[wr_idx % SB_DEPTH] <= steady_mode;
				wr_idx <= wr_idx + 1;
			end
			if (out_valid && out_ready)
				rd_idx <= rd_idx + 1;
		end
	end

	// random back-pressure that is held high in the steady phase
	always @(posedge clk) begin
		if (rst) begin
			ready_rng <= 64'd10248;
			out_ready <= 1'b0;
		end else begin
			ready_rng <= xorshift64(ready_rng);
			out_ready <= steady_mode | ready_rng[7];
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES)
			run_failure($sformatf("timeout: decoder run not finished after %0d cycles",
				cycle));
	end

	assert property (@(posedge clk) disable iff (rst)
		out_valid && out_ready |-> out_item == exp_head)
		else value_mismatch($sformatf("item %0d at loc %h differs from the reference",
			rd_idx, out_item.loc));

	assert property (@(posedge clk) disable iff (rst)
		out_valid |-> rd_idx != wr_idx)
		else run_failure("output stream offered an item that was never sent");

	// empty pipe and ready held high gives two edges from accept to transfer
	assert property (@(posedge clk) disable iff (rst)
		out_valid && out_ready && head_steady |-> cycle == head_cycle + 2)
		else value_mismatch($sformatf("item %0d took %0d cycles instead of 2",
			rd_idx, cycle - head_cycle));

	assert property (@(posedge clk) !rst && $past(rst) |-> in_ready && !out_valid)
		else run_failure("decoder not idle right after reset");

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_item = '0;
		steady_mode = 1'b0;
		stim_rng = 64'd10248;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		run_phase(0, 100);
		run_phase(1, 80);
		run_phase(2, 80);
		run_phase(3, 80);
		run_phase(4, 60);
		run_phase(5, 60);
		run_phase(6, 40);
		drain();
		steady_mode <= 1'b1;
		repeat (3) @(posedge clk);
		run_phase(6, 100);
		drain();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== inst_decoder_top.sv ====
/*
 * MMIX decode front end, top level.
 * Fetch register, combinational operand and X decode, two-entry output
 * buffer, valid/ready streams on both sides.
 */
`timescale 1ns/10ps
`default_nettype none

module inst_decoder_top
	import mmix_dec_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic in_valid,
	output logic in_ready,
	input wire fetch_t in_item,
	output logic out_valid,
	input wire logic out_ready,
	output decoded_t out_item
);

	logic cls_valid;
	classed_t cls_item;
	logic buf_ready;
	spec_t y;
	spec_t z;
	spec_t b;
	dest_t x;
	logic marginal;
	decoded_t dec_item;

	dec_fetch_stage u_fetch (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.in_item (in_item),
		.in_ready (in_ready),
		.buf_ready (buf_ready),
		.cls_valid (cls_valid),
		.cls_item (cls_item)
	);

	dec_operand_spec u_operand (
		.cls_item (cls_item),
		.y (y),
		.z (z)
	);

	dec_dest_rename u_rename (
		.cls_item (cls_item),
		.x (x),
		.b (b),
		.marginal (marginal)
	);

	// decoded item straight from the fetch register
	assign dec_item = '{loc: cls_item.fetch.loc, iop: cls_item.iop, x: x, b: b,
		y: y, z: z, marginal: marginal};

	dec_out_buffer u_buffer (
		.clk (clk),
		.rst (rst),
		.dec_valid (cls_valid),
		.dec_item (dec_item),
		.buf_ready (buf_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_item (out_item)
	);

endmodule

`default_nettype wire

// ==== dec_out_buffer.sv ====
/*
 * Decode output buffer.
 * Two-entry skid buffer between the decoder and the output stream, with
 * a ready that comes from registered occupancy only.
 */
`timescale 1ns/10ps
`default_nettype none

module dec_out_buffer
	import mmix_dec_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic dec_valid,
	input wire decoded_t dec_item,
	output logic buf_ready,
	output logic out_valid,
	input wire logic out_ready,
	output decoded_t out_item
);

	decoded_t entry [0:1];
	logic rd_ptr;
	logic wr_ptr;
	logic [1:0] count;
	logic push;
	logic pop;

	// ready only looks at count, out_ready never reaches upstream
	assign buf_ready = (count != 2'd2);
	assign out_valid = (count != 2'd0);
	assign out_item = entry[rd_ptr];

	assign push = dec_valid && buf_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= 2'd0;
			rd_ptr <= 1'b0;
			wr_ptr <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			case ({push, pop})
			2'b10: count <= count + 2'd1;
			2'b01: count <= count - 2'd1;
			default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			entry[wr_ptr] <= dec_item;
	end

	// stream rule: held until taken, payload unchanged
	assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_item));

	// occupancy and pointers agree, never more than two entries
	assert property (@(posedge clk) disable iff (rst)
		count <= 2'd2 && ((count == 2'd1) == (rd_ptr != wr_ptr)));

endmodule

`default_nettype wire

// ==== dec_dest_rename.sv ====
/*
 * Register X renaming.
 * Maps X to a global or local-ring destination and to the X source
 * operand, and flags a marginal X between L and G.
 */
`timescale 1ns/10ps
`default_nettype none

module dec_dest_rename
	import mmix_dec_pkg::*;
(
	input wire classed_t cls_item,
	output dest_t x,
	output spec_t b,
	output logic marginal
);

	logic [REG_W-1:0] xx;
	logic resolvable;
	spec_t xs;

	assign xx = cls_item.fetch.inst[23:16];
	assign xs = reg_spec(xx, cls_item.fetch.ring);

	// global or live local, anything else sits in the marginal window
	assign resolvable = (xx >= cls_item.fetch.ring.g) || (xx < cls_item.fetch.ring.l);

	always_comb begin
		x = '{ren: 1'b0, src: SRC_KNOWN, regno: '0};
		b = '{val: '0, src: SRC_KNOWN, regno: '0};
		marginal = 1'b0;
		if (cls_item.flags.x_dest) begin
			if (resolvable) begin
				x.ren = 1'b1;
				x.src = xs.src;
				x.regno = xs.regno;
			end else begin
				marginal = 1'b1;
			end
		end
		// marginal source reads as zero
		if (cls_item.flags.x_src && resolvable)
			b = xs;
	end

	// a marginal X is never installed, neither as dest nor as source
	always_comb begin
		if (marginal)
			assert (!x.ren && b.src == SRC_KNOWN && b.val == '0)
				else $error("marginal X was resolved");
	end

endmodule

`default_nettype wire

// ==== dec_operand_spec.sv ====
/*
 * Y and Z operand specification.
 * Resolves immediates and register fields against the ring, builds the
 * wyde immediates and turns relative branch and jump offsets into targets.
 */
`timescale 1ns/10ps
`default_nettype none

module dec_operand_spec
	import mmix_dec_pkg::*;
(
	input wire classed_t cls_item,
	output spec_t y,
	output spec_t z
);

	logic [7:0] op;
	logic [REG_W-1:0] xx;
	logic [REG_W-1:0] yy;
	logic [REG_W-1:0] zz;
	logic [15:0] yz;
	logic [ADDR_W-1:0] loc;
	logic [ADDR_W-1:0] jmp_off;
	logic [ADDR_W-1:0] br_off;
	op_flags_t f;
	ring_t ring;

	assign op = cls_item.fetch.inst[31:24];
	assign xx = cls_item.fetch.inst[23:16];
	assign yy = cls_item.fetch.inst[15:8];
	assign zz = cls_item.fetch.inst[7:0];
	assign yz = cls_item.fetch.inst[15:0];
	assign loc = cls_item.fetch.loc;
	assign f = cls_item.flags;
	assign ring = cls_item.fetch.ring;

	// backward forms have the opcode LSB set, which acts as the sign bit
	assign jmp_off = {{38{op[0]}}, cls_item.fetch.inst[23:0], 2'b00};
	assign br_off = {{46{op[0]}}, yz, 2'b00};

	always_comb begin
		y = '{val: '0, src: SRC_KNOWN, regno: '0};
		z = '{val: '0, src: SRC_KNOWN, regno: '0};
		if (f.rel_addr) begin
			// Y carries the fall-through address
			y.val = loc + 64'd4;
			if (op[7:1] == OP_JMP[7:1])
				z.val = loc + jmp_off;
			else
				z.val = loc + br_off;
		end else begin
			if (f.y_imm)
				y.val = ADDR_W'(yy);
			else if (f.y_reg)
				y = reg_spec(yy, ring);

			if (op[7:4] == WYDE_GROUP) begin
				// low opcode bits pick the wyde position, H first
				case (op[1:0])
				2'd0: z.val = {yz, 48'h0};
				2'd1: z.val = {16'h0, yz, 32'h0};
				2'd2: z.val = {32'h0, yz, 16'h0};
				default: z.val = {48'h0, yz};
				endcase
				// INC/OR/ANDN combine with the old rX
				if (cls_item.iop != op_set)
					y = reg_spec(xx, ring);
			end else if (f.z_imm) begin
				z.val = ADDR_W'(zz);
			end else if (f.z_reg) begin
				z = reg_spec(zz, ring);
			end
		end
	end

endmodule

`default_nettype wire

// ==== dec_fetch_stage.sv ====
/*
 * Decode input stage.
 * Accepts fetched items from the valid/ready stream, maps the opcode to an
 * internal operation class and operand flags, and holds the result in a
 * register until the output buffer takes it.
 */
`timescale 1ns/10ps
`default_nettype none

module dec_fetch_stage
	import mmix_dec_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic in_valid,
	input wire fetch_t in_item,
	output logic in_ready,
	input wire logic buf_ready,
	output logic cls_valid,
	output classed_t cls_item
);

	logic [7:0] op;
	logic advance;
	iop_e nxt_iop;
	op_flags_t nxt_flags;

	assign op = in_item.inst[31:24];

	// register is free when empty or drained this cycle
	assign advance = !cls_valid || buf_ready;
	assign in_ready = advance;

	always_comb begin
		nxt_iop = op_trap;
		nxt_flags = '0;
		case (op[7:4])
		4'h2, 4'h3: begin
			// odd opcode is the immediate-Z form
			nxt_flags = op[0] ? 8'h29 : 8'h2a;
			case (op[4:1])
			4'h0: nxt_iop = op_add;
			4'h1: nxt_iop = op_addu;
			4'h2: nxt_iop = op_sub;
			4'h3: nxt_iop = op_subu;
			4'h4, 4'h5, 4'h6, 4'h7: nxt_iop = op_addu;
			4'h8: nxt_iop = op_cmp;
			4'h9: nxt_iop = op_cmpu;
			4'ha: nxt_iop = op_sub;
			4'hb: nxt_iop = op_subu;
			4'hc, 4'hd: nxt_iop = op_shl;
			default: nxt_iop = op_shr;
			endcase
			// NEG family: Y is an immediate
			if (op[7:2] == 6'b001101)
				nxt_flags = op[0] ? 8'h25 : 8'h26;
		end
		4'h4, 4'h5: begin
			nxt_iop = op[4] ? op_pbr : op_br;
			nxt_flags = 8'h50;
		end
		4'h6: begin
			// conditional set also reads X
			nxt_iop = op_cset;
			nxt_flags = op[0] ? 8'h39 : 8'h3a;
		end
		4'h7: begin
			nxt_iop = op_zset;
			nxt_flags = op[0] ? 8'h29 : 8'h2a;
		end
		4'h8: begin
			nxt_iop = op_ld;
			nxt_flags = op[0] ? 8'h29 : 8'h2a;
		end
		4'ha: begin
			// store data comes from X
			nxt_iop = op_st;
			nxt_flags = op[0] ? 8'h19 : 8'h1a;
		end
		4'hc: begin
			nxt_iop = op[3] ? op_and : op_or;
			nxt_flags = op[0] ? 8'h29 : 8'h2a;
		end
		WYDE_GROUP: begin
			// SETx writes X only, INCx/ORx/ANDNx also read it
			case (op[3:2])
			2'b00: nxt_iop = op_set;
			2'b01: nxt_iop = op_addu;
			2'b10: nxt_iop = op_or;
			default: nxt_iop = op_and;
			endcase
			nxt_flags = (op[3:2] == 2'b00) ? 8'h20 : 8'h30;
		end
		4'hf: begin
			if (op[7:1] == OP_JMP[7:1]) begin
				nxt_iop = op_jmp;
				nxt_flags = 8'hc0;
			end
		end
		default: begin
			nxt_iop = op_trap;
			nxt_flags = '0;
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			cls_valid <= 1'b0;
		else if (advance)
			cls_valid <= in_valid;
	end

	// payload register, loaded only on accept
	always_ff @(posedge clk) begin
		if (advance && in_valid)
			cls_item <= '{fetch: in_item, iop: nxt_iop, flags: nxt_flags};
	end

	// a stalled item stays put until the buffer takes it
	assert property (@(posedge clk) disable iff (rst)
		cls_valid && !buf_ready |=> cls_valid && $stable(cls_item));

endmodule

`default_nettype wire

// ==== mmix_dec_pkg.sv ====
/*
 * MMIX decode front end, shared definitions.
 * Widths, ring mask, opcode constants, the internal operation class,
 * operand specification types and the stream payload structs.
 */
`default_nettype none

package mmix_dec_pkg;

	// widths
	localparam int ADDR_W = 64;
	localparam int INST_W = 32;
	localparam int REG_W = 8;
	localparam int RING_W = 61;

	// local register ring is 256 entries deep
	localparam int LRING_MASK = 255;

	// opcode constants
	localparam logic [7:0] OP_JMP = 8'hF0;
	localparam logic [3:0] WYDE_GROUP = 4'hE;

	// internal operation class
	typedef enum logic [4:0] {
		op_trap, op_add, op_addu, op_sub, op_subu, op_cmp, op_cmpu,
		op_shl, op_shr, op_br, op_pbr, op_cset, op_zset, op_ld, op_st,
		op_or, op_and, op_set, op_jmp
	} iop_e;

	// where an operand value comes from
	typedef enum logic [1:0] {
		SRC_KNOWN = 2'd0,
		SRC_GLOBAL = 2'd1,
		SRC_LOCAL = 2'd2
	} spec_src_e;

	// operand flags, ctl_change is bit 7, z_imm is bit 0
	typedef struct packed {
		logic ctl_change;
		logic rel_addr;
		logic x_dest;
		logic x_src;
		logic y_reg;
		logic y_imm;
		logic z_reg;
		logic z_imm;
	} op_flags_t;

	// operand spec: known value or register index in the global file / local ring
	typedef struct packed {
		logic [ADDR_W-1:0] val;
		spec_src_e src;
		logic [REG_W-1:0] regno;
	} spec_t;

	typedef struct packed {
		logic ren;
		spec_src_e src;
		logic [REG_W-1:0] regno;
	} dest_t;

	// register ring state G, L and O
	typedef struct packed {
		logic [REG_W-1:0] g;
		logic [REG_W-1:0] l;
		logic [RING_W-1:0] o;
	} ring_t;

	typedef struct packed {
		logic [INST_W-1:0] inst;
		logic [ADDR_W-1:0] loc;
		ring_t ring;
	} fetch_t;

	typedef struct packed {
		fetch_t fetch;
		iop_e iop;
		op_flags_t flags;
	} classed_t;

	typedef struct packed {
		logic [ADDR_W-1:0] loc;
		iop_e iop;
		dest_t x;
		spec_t b;
		spec_t y;
		spec_t z;
		logic marginal;
	} decoded_t;

	// global when idx >= G, otherwise a slot in the local ring at O + idx
	function automatic spec_t reg_spec(logic [REG_W-1:0] idx, ring_t ring);
		spec_t s;
		logic [RING_W-1:0] slot;
		slot = (ring.o + RING_W'(idx)) & RING_W'(LRING_MASK);
		s.val = '0;
		if (idx >= ring.g) begin
			s.src = SRC_GLOBAL;
			s.regno = idx;
		end else begin
			s.src = SRC_LOCAL;
			s.regno = slot[REG_W-1:0];
		end
		return s;
	endfunction

endpackage

`default_nettype wire
